//--- design/flight_pkg.sv
// Flight control shared types
package flight_pkg;

    // Raw value types
    // Stick value, 0 to 250
    typedef logic [7:0] stick_val_t;
    // Euler angle in IMU counts
    typedef logic signed [15:0] angle_t;
    // Axis rate
    typedef logic signed [15:0] rate_t;
    // Motor command, 0 to 250
    typedef logic [7:0] motor_rate_t;
    // Headroom for differences, shifts and mixer sums
    typedef logic signed [17:0] wide_rate_t;

    // Flight constants
    localparam int STICK_CENTER   = 125;
    localparam int MOTOR_RATE_MAX = 250;
    localparam int RATE_LIMIT     = 250;

    // Receiver sticks
    typedef struct packed {
        stick_val_t throttle;
        stick_val_t yaw;
        stick_val_t roll;
        stick_val_t pitch;
    } stick_cmd_t;

    // One IMU sample, Euler angles then gyro rates
    typedef struct packed {
        angle_t euler_x;
        angle_t euler_y;
        angle_t euler_z;
        rate_t  gyro_x;
        rate_t  gyro_y;
        rate_t  gyro_z;
    } imu_sample_t;

    typedef struct packed {
        rate_t yaw;
        rate_t roll;
        rate_t pitch;
    } axis_rates_t;

    // Angle stage result, gyro travels with its own frame
    typedef struct packed {
        stick_val_t  throttle;
        axis_rates_t target;
        axis_rates_t gyro;
    } rate_request_t;

    typedef struct packed {
        motor_rate_t m1;
        motor_rate_t m2;
        motor_rate_t m3;
        motor_rate_t m4;
    } motor_rates_t;

    // Symmetric clamp to plus or minus RATE_LIMIT
    function automatic rate_t sat_rate(input wide_rate_t v);
        if (v > wide_rate_t'(RATE_LIMIT)) begin
            return rate_t'(RATE_LIMIT);
        end
        if (v < wide_rate_t'(-RATE_LIMIT)) begin
            return rate_t'(-RATE_LIMIT);
        end
        return rate_t'(v);
    endfunction

endpackage

//--- design/angle_controller.sv
// Angle stage
`timescale 1ns/1ps

module angle_controller
    import flight_pkg::*;
#(
    parameter int ANGLE_GAIN_SHIFT = 1
) (
    input  logic          sys_clk,
    input  logic          resetn,
    input  logic          start,
    input  stick_cmd_t    sticks,
    input  imu_sample_t   imu,
    output rate_request_t req,
    output logic          done
);

    // Stick offsets from center, signed
    wide_rate_t roll_tgt;
    wide_rate_t pitch_tgt;
    wide_rate_t yaw_tgt;

    // Angle errors before and after gain
    wide_rate_t roll_err;
    wide_rate_t pitch_err;
    wide_rate_t roll_scaled;
    wide_rate_t pitch_scaled;

    rate_request_t req_next;

    assign roll_tgt  = wide_rate_t'(sticks.roll) - wide_rate_t'(STICK_CENTER);
    assign pitch_tgt = wide_rate_t'(sticks.pitch) - wide_rate_t'(STICK_CENTER);
    assign yaw_tgt   = wide_rate_t'(sticks.yaw) - wide_rate_t'(STICK_CENTER);

    // Roll leans on Euler y, pitch on Euler x
    assign roll_err  = roll_tgt - wide_rate_t'(imu.euler_y);
    assign pitch_err = pitch_tgt - wide_rate_t'(imu.euler_x);

    // Gain as arithmetic shift keeps the sign
    assign roll_scaled  = roll_err >>> ANGLE_GAIN_SHIFT;
    assign pitch_scaled = pitch_err >>> ANGLE_GAIN_SHIFT;

    always_comb begin
        req_next.throttle     = sticks.throttle;
        req_next.target.roll  = sat_rate(roll_scaled);
        req_next.target.pitch = sat_rate(pitch_scaled);
        // Yaw in rate mode, offset is already within limits
        req_next.target.yaw   = rate_t'(yaw_tgt);
        // Gyro mapping roll to x, pitch to y, yaw to z
        req_next.gyro.roll    = imu.gyro_x;
        req_next.gyro.pitch   = imu.gyro_y;
        req_next.gyro.yaw     = imu.gyro_z;
    end

    // Result held until the next strobe
    always_ff @(posedge sys_clk) begin
        if (start) begin
            req <= req_next;
        end
    end

    // Complete strobe one cycle after start
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

endmodule

//--- design/body_rate_controller.sv
// Body-frame rate stage
`timescale 1ns/1ps

module body_rate_controller
    import flight_pkg::*;
#(
    parameter int RATE_GAIN_SHIFT = 1
) (
    input  logic          sys_clk,
    input  logic          resetn,
    input  logic          start,
    input  rate_request_t req,
    output axis_rates_t   rates,
    output stick_val_t    throttle,
    output logic          done
);

    // Rate errors per axis
    wide_rate_t yaw_err;
    wide_rate_t roll_err;
    wide_rate_t pitch_err;

    // After proportional gain
    wide_rate_t yaw_scaled;
    wide_rate_t roll_scaled;
    wide_rate_t pitch_scaled;

    axis_rates_t rates_next;

    // Target minus measured, widened first
    assign yaw_err   = wide_rate_t'(req.target.yaw) - wide_rate_t'(req.gyro.yaw);
    assign roll_err  = wide_rate_t'(req.target.roll) - wide_rate_t'(req.gyro.roll);
    assign pitch_err = wide_rate_t'(req.target.pitch) - wide_rate_t'(req.gyro.pitch);

    assign yaw_scaled   = yaw_err >>> RATE_GAIN_SHIFT;
    assign roll_scaled  = roll_err >>> RATE_GAIN_SHIFT;
    assign pitch_scaled = pitch_err >>> RATE_GAIN_SHIFT;

    // Corrective rates, clamped per axis
    always_comb begin
        rates_next.yaw   = sat_rate(yaw_scaled);
        rates_next.roll  = sat_rate(roll_scaled);
        rates_next.pitch = sat_rate(pitch_scaled);
    end

    // Throttle registered with its own frame
    always_ff @(posedge sys_clk) begin
        if (start) begin
            rates    <= rates_next;
            throttle <= req.throttle;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

endmodule

//--- design/motor_mixer.sv
// Quad-X motor mixer
`timescale 1ns/1ps

module motor_mixer
    import flight_pkg::*;
(
    input  logic         sys_clk,
    input  logic         resetn,
    input  logic         start,
    input  stick_val_t   throttle,
    input  axis_rates_t  rates,
    output motor_rates_t motor_rates,
    output logic         done
);

    // Clamp a wide sum into 0 to MOTOR_RATE_MAX
    function automatic motor_rate_t clamp_motor(input wide_rate_t v);
        if (v < wide_rate_t'(0)) begin
            return '0;
        end
        if (v > wide_rate_t'(MOTOR_RATE_MAX)) begin
            return motor_rate_t'(MOTOR_RATE_MAX);
        end
        return motor_rate_t'(v);
    endfunction

    wide_rate_t thr;
    wide_rate_t yaw;
    wide_rate_t roll;
    wide_rate_t pitch;

    // Raw per-motor sums
    wide_rate_t sum_m1;
    wide_rate_t sum_m2;
    wide_rate_t sum_m3;
    wide_rate_t sum_m4;

    assign thr   = wide_rate_t'(throttle);
    assign yaw   = wide_rate_t'(rates.yaw);
    assign roll  = wide_rate_t'(rates.roll);
    assign pitch = wide_rate_t'(rates.pitch);

    // Front pair gets +pitch, diagonal pairs share yaw sign
    assign sum_m1 = thr + pitch + roll - yaw;
    assign sum_m2 = thr + pitch - roll + yaw;
    assign sum_m3 = thr - pitch - roll - yaw;
    assign sum_m4 = thr - pitch + roll + yaw;

    // Motors idle at zero out of reset
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            motor_rates <= '0;
            done        <= 1'b0;
        end else begin
            done <= start;
            if (start) begin
                motor_rates.m1 <= clamp_motor(sum_m1);
                motor_rates.m2 <= clamp_motor(sum_m2);
                motor_rates.m3 <= clamp_motor(sum_m3);
                motor_rates.m4 <= clamp_motor(sum_m4);
            end
        end
    end

endmodule

//--- design/pwm_generator.sv
// ESC pulse generator
`timescale 1ns/1ps

module pwm_generator
    import flight_pkg::*;
#(
    parameter int TICK_DIV         = 2,
    parameter int PWM_PERIOD_TICKS = 300,
    parameter int PULSE_MIN_TICKS  = 20
) (
    input  logic         sys_clk,
    input  logic         resetn,
    input  motor_rates_t motor_rates,
    output logic [3:0]   motor_pwm
);

    localparam int CYC_W  = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam int TICK_W = $clog2(PWM_PERIOD_TICKS);
    // Wide enough for a tick count and the longest pulse
    localparam int LEN_W  = $clog2(PULSE_MIN_TICKS + MOTOR_RATE_MAX + 1);
    localparam int CMP_W  = (LEN_W > TICK_W) ? LEN_W : TICK_W;

    logic [CYC_W-1:0]  cyc_cnt;
    logic [TICK_W-1:0] tick_cnt;
    logic              tick;
    logic              period_start;

    motor_rates_t      rates_lat;
    motor_rates_t      rates_sel;
    logic [3:0][7:0]   rate_vec;

    assign tick         = (cyc_cnt == CYC_W'(TICK_DIV - 1));
    assign period_start = (cyc_cnt == '0) && (tick_cnt == '0);

    // Sys_clk divider and period tick counter
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            cyc_cnt  <= '0;
            tick_cnt <= '0;
        end else if (tick) begin
            cyc_cnt <= '0;
            if (tick_cnt == TICK_W'(PWM_PERIOD_TICKS - 1)) begin
                tick_cnt <= '0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

    // Rates sampled once per period
    always_ff @(posedge sys_clk) begin
        if (period_start) begin
            rates_lat <= motor_rates;
        end
    end

    // Latch cycle compares against the value being captured
    assign rates_sel = period_start ? motor_rates : rates_lat;

    // Channel 0 drives motor 1
    assign rate_vec = {rates_sel.m4, rates_sel.m3, rates_sel.m2, rates_sel.m1};

    // Registered compare, so each pulse rises the cycle after the latch
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            motor_pwm <= '0;
        end else begin
            for (int ch = 0; ch < 4; ch++) begin
                motor_pwm[ch] <= CMP_W'(tick_cnt) <
                                 (CMP_W'(PULSE_MIN_TICKS) + CMP_W'(rate_vec[ch]));
            end
        end
    end

endmodule

//--- design/flight_core.sv
// Flight control compute top
`timescale 1ns/1ps

module flight_core
    import flight_pkg::*;
#(
    parameter int ANGLE_GAIN_SHIFT = 1,
    parameter int RATE_GAIN_SHIFT  = 1,
    parameter int TICK_DIV         = 2,
    parameter int PWM_PERIOD_TICKS = 300,
    parameter int PULSE_MIN_TICKS  = 20
) (
    input  logic         sys_clk,
    input  logic         resetn,
    input  logic         start,
    input  stick_cmd_t   sticks,
    input  imu_sample_t  imu,
    output logic         done,
    output motor_rates_t motor_rates,
    output logic [3:0]   motor_pwm
);

    // Angle stage to rate stage
    rate_request_t ac_req;
    logic          ac_done;

    // Rate stage to mixer
    axis_rates_t   rc_rates;
    stick_val_t    rc_throttle;
    logic          rc_done;

    // Sticks and angles to rate targets
    angle_controller #(
        .ANGLE_GAIN_SHIFT(ANGLE_GAIN_SHIFT)
    ) u_angle (
        .sys_clk(sys_clk),
        .resetn (resetn),
        .start  (start),
        .sticks (sticks),
        .imu    (imu),
        .req    (ac_req),
        .done   (ac_done)
    );

    // Rate targets against gyro
    body_rate_controller #(
        .RATE_GAIN_SHIFT(RATE_GAIN_SHIFT)
    ) u_rate (
        .sys_clk (sys_clk),
        .resetn  (resetn),
        .start   (ac_done),
        .req     (ac_req),
        .rates   (rc_rates),
        .throttle(rc_throttle),
        .done    (rc_done)
    );

    // Frame completes here, three cycles after start
    motor_mixer u_mixer (
        .sys_clk    (sys_clk),
        .resetn     (resetn),
        .start      (rc_done),
        .throttle   (rc_throttle),
        .rates      (rc_rates),
        .motor_rates(motor_rates),
        .done       (done)
    );

    // Free running, picks up latest motor rates each period
    pwm_generator #(
        .TICK_DIV        (TICK_DIV),
        .PWM_PERIOD_TICKS(PWM_PERIOD_TICKS),
        .PULSE_MIN_TICKS (PULSE_MIN_TICKS)
    ) u_pwm (
        .sys_clk    (sys_clk),
        .resetn     (resetn),
        .motor_rates(motor_rates),
        .motor_pwm  (motor_pwm)
    );

endmodule

//--- sim/flight_asserts.sv
// Flight core protocol assertions
`timescale 1ns/1ps

module flight_asserts
    import flight_pkg::*;
(
    input logic         sys_clk,
    input logic         resetn,
    input logic         start,
    input logic         done,
    input motor_rates_t motor_rates,
    input logic [3:0]   motor_pwm
);

    // Fixed three stage latency
    a_done_latency: assert property (@(posedge sys_clk) disable iff (!resetn)
        start |-> ##3 done)
        else $error("done did not follow start after three cycles");

    // No orphan done
    a_done_source: assert property (@(posedge sys_clk) disable iff (!resetn)
        done |-> $past(start, 3))
        else $error("done without a start three cycles earlier");

    a_rate_range: assert property (@(posedge sys_clk) disable iff (!resetn)
        (motor_rates.m1 <= motor_rate_t'(MOTOR_RATE_MAX)) &&
        (motor_rates.m2 <= motor_rate_t'(MOTOR_RATE_MAX)) &&
        (motor_rates.m3 <= motor_rate_t'(MOTOR_RATE_MAX)) &&
        (motor_rates.m4 <= motor_rate_t'(MOTOR_RATE_MAX)))
        else $error("motor rate above MOTOR_RATE_MAX");

    // Outputs quiet once reset has been seen for a cycle
    a_reset_quiet: assert property (@(posedge sys_clk)
        (!resetn && $past(!resetn)) |-> (motor_pwm == 4'b0 && !done))
        else $error("motor_pwm or done active during reset");

endmodule

bind flight_core flight_asserts u_asserts (
    .sys_clk    (sys_clk),
    .resetn     (resetn),
    .start      (start),
    .done       (done),
    .motor_rates(motor_rates),
    .motor_pwm  (motor_pwm)
);

//--- sim/flight_checker.sv
// Flight core reference model and checker
`timescale 1ns/1ps

module flight_checker
    import flight_pkg::*;
#(
    parameter int ANGLE_GAIN_SHIFT = 1,
    parameter int RATE_GAIN_SHIFT  = 1,
    parameter int TICK_DIV         = 2,
    parameter int PULSE_MIN_TICKS  = 20
) (
    input  logic         sys_clk,
    input  logic         resetn,
    input  logic [2:0]   test_id,
    input  logic         start,
    input  stick_cmd_t   sticks,
    input  imu_sample_t  imu,
    input  logic         done,
    input  motor_rates_t motor_rates,
    input  logic [3:0]   motor_pwm,
    output int           mismatches,
    output int           failures,
    output int           pending,
    output int           pulses
);

    // Expected results and their start cycles, oldest first
    motor_rates_t exp_q[$];
    int           cyc_q[$];
    int           cycle;
    logic         in_reset;

    // PWM pulse measurement per channel
    logic [3:0]   pwm_prev;
    motor_rates_t rates_prev;
    logic [3:0]   measuring;
    int           high_len [4];
    int           want_len [4];

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0:    return "reset_state";
            3'd1:    return "neutral_hover";
            3'd2:    return "random_frames";
            3'd3:    return "back_to_back";
            3'd4:    return "saturation";
            default: return "pwm_widths";
        endcase
    endfunction

    function automatic int limit(input int v, input int lo, input int hi);
        if (v < lo) begin
            return lo;
        end
        if (v > hi) begin
            return hi;
        end
        return v;
    endfunction

    function automatic int rate_of(input motor_rates_t r, input int ch);
        case (ch)
            0:       return int'(r.m1);
            1:       return int'(r.m2);
            2:       return int'(r.m3);
            default: return int'(r.m4);
        endcase
    endfunction

    // Whole frame in integer arithmetic
    function automatic motor_rates_t predict(input stick_cmd_t s, input imu_sample_t m);
        int roll_t;
        int pitch_t;
        int yaw_t;
        int roll_c;
        int pitch_c;
        int yaw_c;
        int thr;
        motor_rates_t r;
        // Angle mode, roll levels on Euler y and pitch on Euler x
        roll_t  = (int'(s.roll) - STICK_CENTER - int'(m.euler_y)) >>> ANGLE_GAIN_SHIFT;
        roll_t  = limit(roll_t, -RATE_LIMIT, RATE_LIMIT);
        pitch_t = (int'(s.pitch) - STICK_CENTER - int'(m.euler_x)) >>> ANGLE_GAIN_SHIFT;
        pitch_t = limit(pitch_t, -RATE_LIMIT, RATE_LIMIT);
        // Yaw stick is a rate target
        yaw_t   = int'(s.yaw) - STICK_CENTER;
        // Rate loop against gyro x, y, z
        roll_c  = limit((roll_t - int'(m.gyro_x)) >>> RATE_GAIN_SHIFT, -RATE_LIMIT, RATE_LIMIT);
        pitch_c = limit((pitch_t - int'(m.gyro_y)) >>> RATE_GAIN_SHIFT, -RATE_LIMIT, RATE_LIMIT);
        yaw_c   = limit((yaw_t - int'(m.gyro_z)) >>> RATE_GAIN_SHIFT, -RATE_LIMIT, RATE_LIMIT);
        thr     = int'(s.throttle);
        // Quad-X mix
        r.m1 = motor_rate_t'(limit(thr + pitch_c + roll_c - yaw_c, 0, MOTOR_RATE_MAX));
        r.m2 = motor_rate_t'(limit(thr + pitch_c - roll_c + yaw_c, 0, MOTOR_RATE_MAX));
        r.m3 = motor_rate_t'(limit(thr - pitch_c - roll_c - yaw_c, 0, MOTOR_RATE_MAX));
        r.m4 = motor_rate_t'(limit(thr - pitch_c + roll_c + yaw_c, 0, MOTOR_RATE_MAX));
        return r;
    endfunction

    task automatic compare(input string what, input int expv, input int actv);
        if (expv != actv) begin
            $display("Mismatch: test %s, %s expected %0d actual %0d",
                     test_name(test_id), what, expv, actv);
            mismatches++;
        end
    endtask

    always @(posedge sys_clk) begin
        motor_rates_t exp;
        int           start_cyc;
        if (!resetn) begin
            exp_q.delete();
            cyc_q.delete();
            cycle      = 0;
            mismatches = 0;
            failures   = 0;
            pulses     = 0;
            pwm_prev   = '0;
            measuring  = '0;
            in_reset   = 1'b1;
        end else begin
            cycle = cycle + 1;
            // First active edge still shows the reset values
            if (in_reset) begin
                in_reset = 1'b0;
                for (int ch = 0; ch < 4; ch++) begin
                    compare($sformatf("motor%0d rate", ch + 1), 0, rate_of(motor_rates, ch));
                end
                compare("done", 0, int'(done));
                compare("motor_pwm", 0, int'(motor_pwm));
            end
            if (done) begin
                if (exp_q.size() == 0) begin
                    $display("Error: done strobe at cycle %0d with no frame in flight", cycle);
                    failures++;
                end else begin
                    exp       = exp_q.pop_front();
                    start_cyc = cyc_q.pop_front();
                    if (cycle != start_cyc + 3) begin
                        $display("Error: frame started at cycle %0d finished at cycle %0d",
                                 start_cyc, cycle);
                        failures++;
                    end
                    for (int ch = 0; ch < 4; ch++) begin
                        compare($sformatf("motor%0d rate", ch + 1), rate_of(exp, ch),
                                rate_of(motor_rates, ch));
                    end
                end
            end
            // Oldest frame overdue
            if (cyc_q.size() != 0 && cycle > cyc_q[0] + 3) begin
                $display("Error: no done strobe for frame started at cycle %0d", cyc_q[0]);
                failures++;
                exp_q.delete(0);
                cyc_q.delete(0);
            end
            if (start) begin
                exp_q.push_back(predict(sticks, imu));
                cyc_q.push_back(cycle);
            end
            // Pulse width set by the rate present when the channel rose
            for (int ch = 0; ch < 4; ch++) begin
                if (motor_pwm[ch] && !pwm_prev[ch]) begin
                    measuring[ch] = 1'b1;
                    high_len[ch]  = 1;
                    want_len[ch]  = TICK_DIV * (PULSE_MIN_TICKS + rate_of(rates_prev, ch));
                end else if (motor_pwm[ch] && measuring[ch]) begin
                    high_len[ch]++;
                end else if (!motor_pwm[ch] && measuring[ch]) begin
                    measuring[ch] = 1'b0;
                    pulses++;
                    compare($sformatf("pwm%0d high cycles", ch + 1), want_len[ch], high_len[ch]);
                end
            end
            pwm_prev   = motor_pwm;
            rates_prev = motor_rates;
        end
        pending = exp_q.size();
    end

endmodule

//--- sim/flight_tb.sv
// Flight core testbench
`timescale 1ns/1ps

module flight_tb
    import flight_pkg::*;
#(
    parameter int ANGLE_GAIN_SHIFT = 1,
    parameter int RATE_GAIN_SHIFT  = 1,
    parameter int TICK_DIV         = 2,
    parameter int PWM_PERIOD_TICKS = 300,
    parameter int PULSE_MIN_TICKS  = 20,
    parameter int RANDOM_FRAMES    = 200
) ();

    localparam int CLK_NS      = 40;
    // Frames of all tests
    localparam int FRAME_COUNT = RANDOM_FRAMES + 20;
    localparam int PERIOD_CYC  = PWM_PERIOD_TICKS * TICK_DIV;
    localparam int WATCHDOG_NS = CLK_NS * (FRAME_COUNT * 3 + 6 * PERIOD_CYC + 1000);

    logic         sys_clk;
    logic         resetn;
    logic         start;
    stick_cmd_t   sticks;
    imu_sample_t  imu;
    logic         done;
    motor_rates_t motor_rates;
    logic [3:0]   motor_pwm;

    logic [2:0]   test_id;
    int           mismatches;
    int           failures;
    int           pending;
    int           pulses;
    int           tb_errors;
    int           pulses_before;
    integer       seed;

    flight_core #(
        .ANGLE_GAIN_SHIFT(ANGLE_GAIN_SHIFT),
        .RATE_GAIN_SHIFT (RATE_GAIN_SHIFT),
        .TICK_DIV        (TICK_DIV),
        .PWM_PERIOD_TICKS(PWM_PERIOD_TICKS),
        .PULSE_MIN_TICKS (PULSE_MIN_TICKS)
    ) DUT (
        .sys_clk    (sys_clk),
        .resetn     (resetn),
        .start      (start),
        .sticks     (sticks),
        .imu        (imu),
        .done       (done),
        .motor_rates(motor_rates),
        .motor_pwm  (motor_pwm)
    );

    flight_checker #(
        .ANGLE_GAIN_SHIFT(ANGLE_GAIN_SHIFT),
        .RATE_GAIN_SHIFT (RATE_GAIN_SHIFT),
        .TICK_DIV        (TICK_DIV),
        .PULSE_MIN_TICKS (PULSE_MIN_TICKS)
    ) u_checker (
        .sys_clk    (sys_clk),
        .resetn     (resetn),
        .test_id    (test_id),
        .start      (start),
        .sticks     (sticks),
        .imu        (imu),
        .done       (done),
        .motor_rates(motor_rates),
        .motor_pwm  (motor_pwm),
        .mismatches (mismatches),
        .failures   (failures),
        .pending    (pending),
        .pulses     (pulses)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_NS / 2) sys_clk = ~sys_clk;
    end

    // Inputs change 1 ns after the rising edge
    task automatic step(input int n);
        if (n > 0) begin
            repeat (n) @(posedge sys_clk);
            #1;
        end
    endtask

    task automatic send_frame(input stick_cmd_t s, input imu_sample_t m);
        sticks = s;
        imu    = m;
        start  = 1'b1;
        step(1);
        start  = 1'b0;
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        while (!done && waited < 10) begin
            step(1);
            waited++;
        end
        if (!done) begin
            $display("Error: no done strobe within 10 cycles of start");
            tb_errors++;
        end
    endtask

    // Until every queued frame has completed
    task automatic drain();
        int waited;
        waited = 0;
        while (pending != 0 && waited < 20) begin
            step(1);
            waited++;
        end
        if (pending != 0) begin
            $display("Error: %0d frames still in flight after 20 cycles", pending);
            tb_errors++;
        end
    endtask

    function automatic stick_cmd_t set_sticks(input stick_val_t thr, input stick_val_t axes);
        stick_cmd_t s;
        s.throttle = thr;
        s.yaw      = axes;
        s.roll     = axes;
        s.pitch    = axes;
        return s;
    endfunction

    function automatic stick_cmd_t rand_sticks();
        stick_cmd_t s;
        s.throttle = stick_val_t'($unsigned($random(seed)) % 251);
        s.yaw      = stick_val_t'($unsigned($random(seed)) % 251);
        s.roll     = stick_val_t'($unsigned($random(seed)) % 251);
        s.pitch    = stick_val_t'($unsigned($random(seed)) % 251);
        return s;
    endfunction

    // Angles and rates within plus or minus span
    function automatic imu_sample_t rand_imu(input int a_span, input int g_span);
        imu_sample_t m;
        m.euler_x = angle_t'($random(seed) % a_span);
        m.euler_y = angle_t'($random(seed) % a_span);
        m.euler_z = angle_t'($random(seed) % a_span);
        m.gyro_x  = rate_t'($random(seed) % g_span);
        m.gyro_y  = rate_t'($random(seed) % g_span);
        m.gyro_z  = rate_t'($random(seed) % g_span);
        return m;
    endfunction

    function automatic imu_sample_t flat_imu(input angle_t a, input rate_t g);
        imu_sample_t m;
        m.euler_x = a;
        m.euler_y = a;
        m.euler_z = a;
        m.gyro_x  = g;
        m.gyro_y  = g;
        m.gyro_z  = g;
        return m;
    endfunction

    initial begin
        seed      = 32'h1497;
        resetn    = 1'b0;
        start     = 1'b0;
        sticks    = '0;
        imu       = '0;
        test_id   = 3'd0;
        tb_errors = 0;
        step(5);
        resetn = 1'b1;
        // Checker looks at the reset state on the first active edge
        step(2);

        test_id = 3'd1;
        send_frame(set_sticks(8'd0, 8'd125), '0);
        wait_done();
        send_frame(set_sticks(8'd137, 8'd125), '0);
        wait_done();
        send_frame(set_sticks(8'd250, 8'd125), '0);
        wait_done();

        // Gaps of zero to three idle cycles
        test_id = 3'd2;
        repeat (RANDOM_FRAMES) begin
            send_frame(rand_sticks(), rand_imu(200, 300));
            step($unsigned($random(seed)) % 4);
        end
        drain();

        test_id = 3'd3;
        repeat (8) send_frame(rand_sticks(), rand_imu(200, 300));
        drain();

        // Full-scale inputs drive every limit
        test_id = 3'd4;
        send_frame(set_sticks(8'd250, 8'd250), flat_imu(-16'sd32768, -16'sd32768));
        wait_done();
        send_frame(set_sticks(8'd0, 8'd0), flat_imu(16'sd32767, 16'sd32767));
        wait_done();
        repeat (6) send_frame(rand_sticks(), rand_imu(32768, 32768));
        drain();

        // One frame followed by two idle PWM periods
        test_id       = 3'd5;
        pulses_before = pulses;
        send_frame(rand_sticks(), rand_imu(200, 300));
        wait_done();
        step(2 * PERIOD_CYC);
        if (pulses == pulses_before) begin
            $display("Error: no PWM pulse completed during the idle periods");
            tb_errors++;
        end

        $display("Error counts: mismatches %0d, protocol %0d, testbench %0d",
                 mismatches, failures, tb_errors);
        if (mismatches + failures + tb_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Error: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Error counts: mismatches %0d, protocol %0d, testbench %0d",
                 mismatches, failures, tb_errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- sim.f
design/flight_pkg.sv
design/angle_controller.sv
design/body_rate_controller.sv
design/motor_mixer.sv
design/pwm_generator.sv
design/flight_core.sv
sim/flight_asserts.sv
sim/flight_checker.sv
sim/flight_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = flight_tb
FILELIST = sim.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG) || ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "Simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
